// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --timing
TOP       := tb_issue_core
FILELIST  := issue_core.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := No errors

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== alu_lanes.sv ====
module alu_lanes import issue_pkg::*; (
  input  logic          clk,
  input  logic          rst,
  input  issue_t [1:0]  issue,
  output done_t  [1:0]  done
);

  logic [data_w-1:0] rf [num_regs];
  logic [data_w-1:0] result [2];

  // ----------------------------------------
  // Operand read and execute
  // ----------------------------------------
  always_comb begin
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] imm;
    for (int k = 0; k < 2; k++) begin
      a   = rf[issue[k].entry.src1];
      b   = rf[issue[k].entry.operand.reg_form.src2];
      imm = issue[k].entry.operand.imm_form.imm;
      case (issue[k].entry.op)
        op_add:  result[k] = a + b;
        op_sub:  result[k] = a - b;
        op_and:  result[k] = a & b;
        op_xor:  result[k] = a ^ b;
        op_addi: result[k] = a + imm;
        op_li:   result[k] = imm;
        default: result[k] = '0;
      endcase
    end
  end

  // ----------------------------------------
  // Writeback and completion
  // ----------------------------------------
  // Destinations of the two lanes never collide, so both write freely
  always_ff @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      done[k].dst   <= issue[k].entry.dst;
      done[k].seq   <= issue[k].entry.seq;
      done[k].value <= result[k];
    end
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        rf[i] <= '0;
      end
      done[0].valid <= 1'b0;
      done[1].valid <= 1'b0;
    end else begin
      for (int k = 0; k < 2; k++) begin
        if (issue[k].valid) begin
          rf[issue[k].entry.dst] <= result[k];
        end
        done[k].valid <= issue[k].valid;             // Pulses one cycle per issue
      end
    end
  end

endmodule

// ==== hazard_scoreboard.sv ====
module hazard_scoreboard import issue_pkg::*; (
  input  logic                    clk,
  input  logic                    rst,
  input  logic      [1:0]         accept,
  input  iq_entry_t [1:0]         accept_entry,
  input  issue_t    [1:0]         issue,
  input  done_t     [1:0]         wb,
  output logic      [num_regs-1:0] src_ready,
  output logic      [num_regs-1:0] dst_free
);

  logic [num_regs-1:0] pend_wr;
  logic [num_regs-1:0] pend_wr_nxt;
  logic [rd_cnt_w-1:0] rd_cnt     [num_regs];
  logic [rd_cnt_w-1:0] rd_cnt_nxt [num_regs];

  // ----------------------------------------
  // Next state per register
  // ----------------------------------------
  always_comb begin
    logic [reg_idx_w-1:0] r;
    logic                 set_wr;
    logic                 clr_wr;
    logic [1:0]           inc;
    logic [1:0]           dec;
    for (int i = 0; i < num_regs; i++) begin
      r      = reg_idx_w'(i);
      set_wr = 1'b0;
      clr_wr = 1'b0;
      inc    = '0;
      dec    = '0;
      for (int k = 0; k < 2; k++) begin
        set_wr = set_wr || (accept[k] && accept_entry[k].dst == r);
        clr_wr = clr_wr || (wb[k].valid && wb[k].dst == r);
        inc    = inc + 2'(accept[k] && reads_reg(accept_entry[k], r));
        dec    = dec + 2'(issue[k].valid && reads_reg(issue[k].entry, r));
      end
      // A writeback and a new writer never meet on one register
      pend_wr_nxt[i] = (pend_wr[i] && !clr_wr) || set_wr;
      rd_cnt_nxt[i]  = rd_cnt[i] + rd_cnt_w'(inc) - rd_cnt_w'(dec);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_wr <= '0;
      for (int i = 0; i < num_regs; i++) begin
        rd_cnt[i] <= '0;
      end
    end else begin
      pend_wr <= pend_wr_nxt;
      for (int i = 0; i < num_regs; i++) begin
        rd_cnt[i] <= rd_cnt_nxt[i];
      end
    end
  end

  // ----------------------------------------
  // Status to dispatch and select
  // ----------------------------------------
  assign src_ready = ~pend_wr;

  always_comb begin
    for (int i = 0; i < num_regs; i++) begin
      dst_free[i] = !pend_wr[i] && (rd_cnt[i] == '0);  // No WAW and no WAR
    end
  end

endmodule

// ==== issue_core.f ====
issue_pkg.sv
issue_queue.sv
issue_select.sv
hazard_scoreboard.sv
alu_lanes.sv
issue_core.sv
tb_issue_core.sv

// ==== issue_core.sv ====
module issue_core import issue_pkg::*; (
  input  logic            clk,
  input  logic            rst,
  input  logic      [1:0] in_valid,
  input  iq_entry_t [1:0] in_entry,
  output logic      [1:0] in_ready,
  output done_t     [1:0] done
);

  logic                            [1:0] accept;
  iq_entry_t [iq_entries-1:0]            slot_entry;
  logic      [iq_entries-1:0]            slot_valid;
  logic                            [3:0] free;
  logic                            [1:0] pop;
  logic      [1:0] [iq_key_w-1:0]        pop_key;
  logic      [num_regs-1:0]              src_ready;
  logic      [num_regs-1:0]              dst_free;
  issue_t                          [1:0] issue_q;
  logic                                  cross_hazard;
  logic                                  lane1_ok;

  // ----------------------------------------
  // Dispatch handshake
  // ----------------------------------------
  // Lane 1 must not write what lane 0 reads, nor read or write lane 0's result
  assign cross_hazard = (in_entry[0].dst == in_entry[1].dst) ||
                        reads_reg(in_entry[1], in_entry[0].dst) ||
                        reads_reg(in_entry[0], in_entry[1].dst);

  assign lane1_ok = (free >= 4'd2) && dst_free[in_entry[1].dst] &&
                    !(in_valid[0] && cross_hazard);

  assign in_ready[0] = (free >= 4'd1) && dst_free[in_entry[0].dst];
  assign in_ready[1] = in_ready[0] && lane1_ok && (in_valid[0] || !in_valid[1]);
  assign accept      = in_valid & in_ready;

  issue_queue queue_i (
    .clk        (clk),
    .rst        (rst),
    .push       (accept),
    .push_entry (in_entry),
    .pop        (pop),
    .pop_key    (pop_key),
    .slot_entry (slot_entry),
    .slot_valid (slot_valid),
    .free       (free)
  );

  issue_select select_i (
    .slot_entry (slot_entry),
    .slot_valid (slot_valid),
    .src_ready  (src_ready),
    .pop        (pop),
    .pop_key    (pop_key)
  );

  hazard_scoreboard scoreboard_i (
    .clk          (clk),
    .rst          (rst),
    .accept       (accept),
    .accept_entry (in_entry),
    .issue        (issue_q),
    .wb           (done),
    .src_ready    (src_ready),
    .dst_free     (dst_free)
  );

  // ----------------------------------------
  // Issue registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    for (int k = 0; k < 2; k++) begin
      issue_q[k].entry <= slot_entry[pop_key[k]];    // Captured as the queue pops
    end
    if (rst) begin
      issue_q[0].valid <= 1'b0;
      issue_q[1].valid <= 1'b0;
    end else begin
      issue_q[0].valid <= pop[0];
      issue_q[1].valid <= pop[1];
    end
  end

  alu_lanes alu_i (
    .clk   (clk),
    .rst   (rst),
    .issue (issue_q),
    .done  (done)
  );

endmodule

// ==== issue_pkg.sv ====
package issue_pkg;

  // ----------------------------------------
  // Sizes
  // ----------------------------------------
  localparam int iq_entries = 8;
  localparam int iq_key_w   = 3;                     // Pop key, relative to the oldest entry
  localparam int num_regs   = 16;
  localparam int reg_idx_w  = 4;
  localparam int data_w     = 16;
  localparam int seq_w      = 8;
  localparam int rd_cnt_w   = 4;                     // Holds up to iq_entries pending readers

  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_xor  = 3'd3,
    op_addi = 3'd4,
    op_li   = 3'd5
  } op_e;

  // ----------------------------------------
  // Instruction formats
  // ----------------------------------------
  // The second operand word is decoded by the opcode
  typedef union packed {
    struct packed {
      logic [reg_idx_w-1:0]        src2;
      logic [data_w-reg_idx_w-1:0] spare;
    } reg_form;
    struct packed {
      logic [data_w-1:0] imm;
    } imm_form;
  } operand_u;

  typedef struct packed {
    op_e                  op;
    logic [reg_idx_w-1:0] dst;
    logic [reg_idx_w-1:0] src1;                      // Ignored by op_li
    operand_u             operand;
    logic [seq_w-1:0]     seq;
  } iq_entry_t;

  typedef struct packed {
    logic      valid;
    iq_entry_t entry;
  } issue_t;

  typedef struct packed {
    logic                 valid;
    logic [reg_idx_w-1:0] dst;
    logic [seq_w-1:0]     seq;
    logic [data_w-1:0]    value;
  } done_t;

  function automatic logic reads_src1(op_e op);
    return op != op_li;
  endfunction

  function automatic logic reads_src2(op_e op);
    return op inside {op_add, op_sub, op_and, op_xor};
  endfunction

  // True when the entry reads register r through any operand it uses
  function automatic logic reads_reg(iq_entry_t e, logic [reg_idx_w-1:0] r);
    return (reads_src1(e.op) && e.src1 == r) ||
           (reads_src2(e.op) && e.operand.reg_form.src2 == r);
  endfunction

endpackage

// ==== issue_queue.sv ====
module issue_queue import issue_pkg::*; (
  input  logic                               clk,
  input  logic                               rst,
  input  logic      [1:0]                    push,
  input  iq_entry_t [1:0]                    push_entry,
  input  logic      [1:0]                    pop,
  input  logic      [1:0] [iq_key_w-1:0]     pop_key,
  output iq_entry_t [iq_entries-1:0]         slot_entry,
  output logic      [iq_entries-1:0]         slot_valid,
  output logic      [3:0]                    free
);

  // One extra pointer bit tells a full queue from an empty one
  logic [iq_key_w:0]   wr_ptr;
  logic [iq_key_w:0]   rd_ptr;
  logic [iq_key_w:0]   used;
  logic [iq_key_w-1:0] wr_idx;
  logic [iq_key_w-1:0] rd_idx;
  logic [iq_key_w-1:0] wr_idx1;

  iq_entry_t             data [iq_entries];
  logic [iq_entries-1:0] vld;

  logic [1:0] popped_head;                           // Head slot k is popped this cycle
  logic [1:0] head_gone;                             // Head slot k is empty after this edge
  logic [1:0] rd_adv;

  assign wr_idx  = wr_ptr[iq_key_w-1:0];
  assign rd_idx  = rd_ptr[iq_key_w-1:0];
  assign wr_idx1 = wr_idx + iq_key_w'(push[0]);      // Lane 1 follows lane 0 when both push
  assign used    = wr_ptr - rd_ptr;
  assign free    = 4'(iq_entries) - 4'(used);

  // ----------------------------------------
  // Oldest-first view of the storage
  // ----------------------------------------
  always_comb begin
    logic [iq_key_w-1:0] phys;
    for (int j = 0; j < iq_entries; j++) begin
      phys          = rd_idx + iq_key_w'(j);
      slot_entry[j] = data[phys];
      slot_valid[j] = vld[phys];
    end
  end

  // ----------------------------------------
  // Head reclaim
  // ----------------------------------------
  // A slot counts as gone if it was already a hole or is popped now
  always_comb begin
    for (int k = 0; k < 2; k++) begin
      popped_head[k] = (pop[0] && pop_key[0] == iq_key_w'(k)) ||
                       (pop[1] && pop_key[1] == iq_key_w'(k));
    end
    head_gone[0] = (used > 0) &&
                   (!vld[rd_idx] || popped_head[0]);
    head_gone[1] = head_gone[0] && (used > 1) &&
                   (!vld[rd_idx + iq_key_w'(1)] || popped_head[1]);
    if (head_gone[1]) begin
      rd_adv = 2'd2;
    end else if (head_gone[0]) begin
      rd_adv = 2'd1;
    end else begin
      rd_adv = 2'd0;
    end
  end

  // ----------------------------------------
  // Pointer and valid state
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      vld    <= '0;
    end else begin
      // Pops may leave holes anywhere in the live range
      for (int k = 0; k < 2; k++) begin
        if (pop[k]) begin
          vld[rd_idx + pop_key[k]] <= 1'b0;
        end
      end
      if (push[0]) begin
        vld[wr_idx] <= 1'b1;
      end
      if (push[1]) begin
        vld[wr_idx1] <= 1'b1;
      end
      wr_ptr <= wr_ptr + (iq_key_w+1)'(push[0]) + (iq_key_w+1)'(push[1]);
      rd_ptr <= rd_ptr + (iq_key_w+1)'(rd_adv);
    end
  end

  // Payload storage
  always_ff @(posedge clk) begin
    if (push[0]) begin
      data[wr_idx] <= push_entry[0];
    end
    if (push[1]) begin
      data[wr_idx1] <= push_entry[1];
    end
  end

endmodule

// ==== issue_select.sv ====
module issue_select import issue_pkg::*; (
  input  iq_entry_t [iq_entries-1:0]     slot_entry,
  input  logic      [iq_entries-1:0]     slot_valid,
  input  logic      [num_regs-1:0]       src_ready,
  output logic      [1:0]                pop,
  output logic      [1:0] [iq_key_w-1:0] pop_key
);

  logic [iq_entries-1:0] eligible;

  // ----------------------------------------
  // Per-slot readiness
  // ----------------------------------------
  // A source equal to the entry's own destination is always ready,
  // since dispatch only accepts a destination with no older writer
  always_comb begin
    logic                 src1_ok;
    logic                 src2_ok;
    logic [reg_idx_w-1:0] src2;
    for (int j = 0; j < iq_entries; j++) begin
      src2    = slot_entry[j].operand.reg_form.src2;
      src1_ok = !reads_src1(slot_entry[j].op) ||
                src_ready[slot_entry[j].src1] ||
                (slot_entry[j].src1 == slot_entry[j].dst);
      src2_ok = !reads_src2(slot_entry[j].op) ||
                src_ready[src2] ||
                (src2 == slot_entry[j].dst);
      eligible[j] = slot_valid[j] && src1_ok && src2_ok;
    end
  end

  // ----------------------------------------
  // Two oldest eligible slots
  // ----------------------------------------
  always_comb begin
    pop     = '0;
    pop_key = '0;
    for (int j = 0; j < iq_entries; j++) begin
      if (eligible[j]) begin
        if (!pop[0]) begin
          pop[0]     = 1'b1;                         // Oldest eligible
          pop_key[0] = iq_key_w'(j);
        end else if (!pop[1]) begin
          pop[1]     = 1'b1;                         // Next oldest eligible
          pop_key[1] = iq_key_w'(j);
        end
      end
    end
  end

endmodule

// ==== tb_issue_core.sv ====
module tb_issue_core import issue_pkg::*; ();

  localparam int n_random    = 200;
  localparam int n_chain     = 5;                    // Links that write r1 to r5 in turn
  localparam int n_fill_adds = 8;
  localparam int total_instr = n_random + n_chain + n_fill_adds;
  localparam int max_cycles  = n_random * 20;

  logic            clk;
  logic            rst;
  logic      [1:0] in_valid;
  iq_entry_t [1:0] in_entry;
  logic      [1:0] in_ready;
  done_t     [1:0] done;

  iq_entry_t            prog       [total_instr];
  logic [reg_idx_w-1:0] exp_dst    [total_instr];
  logic [data_w-1:0]    exp_val    [total_instr];
  bit                   seen       [total_instr];
  int                   done_cycle [total_instr];
  int                   op_count   [8];
  int                   next_idx       = 0;
  int                   accepted_total = 0;
  int                   done_total     = 0;
  int                   error_count    = 0;
  int                   stall_count    = 0;
  int                   cycle_count    = 0;
  bit                   fill_phase     = 1'b0;

  issue_core dut_i (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_entry (in_entry),
    .in_ready (in_ready),
    .done     (done)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Ends the run at a fixed cycle limit
  initial begin
    while (cycle_count < max_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles: %0d errors, %0d of %0d completions",
             cycle_count, error_count, done_total, total_instr);
    $display("Errors found");
    $finish;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, expected);
      error_count++;
    end
  endtask

  // ----------------------------------------
  // Program and in-order reference
  // ----------------------------------------
  function automatic void build_random_program();
    iq_entry_t e;
    for (int i = 0; i < n_random; i++) begin
      e      = '0;
      e.op   = op_e'(3'($urandom % 6));
      e.dst  = reg_idx_w'($urandom % 6);             // Few registers so hazards are common
      e.src1 = reg_idx_w'($urandom % 6);
      if (e.op == op_li || e.op == op_addi) begin
        e.operand.imm_form.imm = data_w'($urandom);
      end else begin
        e.operand.reg_form.src2  = reg_idx_w'($urandom % 6);
        e.operand.reg_form.spare = (data_w-reg_idx_w)'($urandom);
      end
      e.seq         = seq_w'(i);
      prog[i]       = e;
    end
  endfunction

  // A chain li r1, addi r2..r5 keeps r5 pending while eight adds read it
  function automatic void build_fill_program();
    iq_entry_t e;
    for (int i = 0; i < n_chain + n_fill_adds; i++) begin
      e = '0;
      if (i < n_chain) begin
        e.op                   = (i == 0) ? op_li : op_addi;
        e.dst                  = reg_idx_w'(i + 1);
        e.src1                 = reg_idx_w'(i);
        e.operand.imm_form.imm = data_w'($urandom);
      end else begin
        e.op                     = op_add;
        e.dst                    = reg_idx_w'(i + 1);  // r6 to r13, all distinct
        e.src1                   = reg_idx_w'(n_chain);
        e.operand.reg_form.src2  = reg_idx_w'(n_chain);
        e.operand.reg_form.spare = (data_w-reg_idx_w)'($urandom);
      end
      e.seq                 = seq_w'(n_random + i);
      prog[n_random + i]    = e;
    end
  endfunction

  function automatic void build_reference();
    logic [data_w-1:0] model_rf [num_regs];
    logic [data_w-1:0] a;
    logic [data_w-1:0] b;
    logic [data_w-1:0] r;
    for (int i = 0; i < num_regs; i++) begin
      model_rf[i] = '0;
    end
    for (int i = 0; i < total_instr; i++) begin
      a = model_rf[prog[i].src1];
      if (prog[i].op == op_li) begin
        r = prog[i].operand.imm_form.imm;
      end else if (prog[i].op == op_addi) begin
        r = a + prog[i].operand.imm_form.imm;
      end else begin
        b = model_rf[prog[i].operand.reg_form.src2];
        case (prog[i].op)
          op_add:  r = a + b;
          op_sub:  r = a - b;
          op_and:  r = a & b;
          default: r = a ^ b;                        // op_xor
        endcase
      end
      model_rf[prog[i].dst] = r;
      exp_dst[i]            = prog[i].dst;
      exp_val[i]            = r;
    end
  endfunction

  // ----------------------------------------
  // Dispatch driver
  // ----------------------------------------
  task automatic dispatch_range(input int last);
    logic [1:0] acc;
    while (next_idx < last) begin
      in_valid[0] = 1'b1;
      in_entry[0] = prog[next_idx];
      in_valid[1] = (next_idx + 1 < last);
      in_entry[1] = (next_idx + 1 < last) ? prog[next_idx + 1] : '0;
      @(negedge clk);
      acc = in_valid & in_ready;
      @(posedge clk);
      #10;
      if (acc[0]) begin
        next_idx       += acc[1] ? 2 : 1;            // Entry is held until accepted
        accepted_total += acc[1] ? 2 : 1;
      end
    end
    in_valid = '0;
    in_entry = '0;
  endtask

  task automatic wait_for_completions(input int n);
    while (done_total < n) begin
      @(posedge clk);
    end
    #10;
  endtask

  // Completion and handshake monitor
  always @(negedge clk) begin
    int s;
    if (!rst) begin
      for (int k = 0; k < 2; k++) begin
        if (done[k].valid === 1'b1) begin
          s = int'(done[k].seq);
          if (s >= total_instr) begin
            $display("%0t Completion with unknown seq %0d on lane %0d", $time, s, k);
            error_count++;
          end else if (seen[s]) begin
            $display("%0t Seq %0d completed a second time on lane %0d", $time, s, k);
            error_count++;
          end else begin
            seen[s]       = 1'b1;
            done_cycle[s] = cycle_count;
            done_total++;
            op_count[int'(prog[s].op)]++;
            check_value($sformatf("done[%0d].dst seq %0d", k, s),
                        32'(done[k].dst), 32'(exp_dst[s]));
            check_value($sformatf("done[%0d].value seq %0d", k, s),
                        32'(done[k].value), 32'(exp_val[s]));
          end
        end
      end
      if (in_valid[1] && in_ready[1] && !(in_valid[0] && in_ready[0])) begin
        $display("%0t Lane 1 was accepted without lane 0", $time);
        error_count++;
      end
      if (fill_phase && in_valid[0] && !in_ready[0]) begin
        stall_count++;                               // Only a full queue stalls lane 0 here
        if (accepted_total - done_total < iq_entries) begin
          $display("%0t Dispatch stalled with only %0d instructions outstanding",
                   $time, accepted_total - done_total);
          error_count++;
        end
      end
    end
  end

  task automatic final_checks();
    int tail;
    tail = n_random + n_chain - 1;
    for (int i = 0; i < total_instr; i++) begin
      if (!seen[i]) begin
        $display("Seq %0d never completed", i);
        error_count++;
      end
    end
    for (int i = tail + 1; i < total_instr; i++) begin
      if (seen[i] && seen[tail] && done_cycle[i] <= done_cycle[tail]) begin
        $display("Fill add seq %0d completed before the r5 writer", i);
        error_count++;
      end
    end
    if (stall_count == 0) begin
      $display("Dispatch never stalled on a full queue in the fill test");
      error_count++;
    end
    if (op_count[int'(op_li)] == 0 || op_count[int'(op_addi)] == 0 ||
        op_count[int'(op_sub)] == 0 || op_count[int'(op_xor)] == 0) begin
      $display("Some immediate or register form opcode never completed");
      error_count++;
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    rst      = 1'b1;
    in_valid = '0;
    in_entry = '0;
    void'($urandom(17));
    build_random_program();
    build_fill_program();
    build_reference();
    repeat (2) @(posedge clk);
    #10;
    rst = 1'b0;
    @(negedge clk);
    check_value("done[0].valid", 32'(done[0].valid), 32'd0);
    check_value("done[1].valid", 32'(done[1].valid), 32'd0);
    check_value("in_ready", 32'(in_ready), 32'd3);   // Both lanes open after reset
    @(posedge clk);
    #10;
    // Lane 1 alone is held off until lane 0 is valid
    in_valid[1] = 1'b1;
    in_entry[1] = prog[0];
    @(negedge clk);
    check_value("in_ready[1]", 32'(in_ready[1]), 32'd0);
    @(posedge clk);
    #10;
    in_valid = '0;
    in_entry = '0;
    dispatch_range(n_random);
    wait_for_completions(n_random);
    fill_phase = 1'b1;
    dispatch_range(total_instr);
    wait_for_completions(total_instr);
    fill_phase = 1'b0;
    repeat (4) @(posedge clk);                       // Room for a late duplicate
    final_checks();
    $display("Run finished: %0d errors, %0d of %0d completions",
             error_count, done_total, total_instr);
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
